// File: flist.f
hw/isa_pkg.sv
hw/uop_pkg.sv
hw/insn_cracker.sv
hw/slot_allocator.sv
hw/bundle_assembler.sv
hw/issue_fsm.sv
hw/bundle_regs.sv
hw/decode_top.sv
sim/clk_gen.sv
sim/decode_assert.sv
sim/decode_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= decode_tb
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Testbench passed" $(LOG); then \
	  echo "simulation gave no result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/decode_tb.sv
module decode_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import isa_pkg::*;
  import uop_pkg::*;

  localparam int LANES        = 2;
  localparam int SLOTS        = 2*LANES;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int N_CYCLES     = 2000;
  localparam int SEED         = 35;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + N_CYCLES) * CLK_PERIOD + 1000;
  localparam opcode_e ALU_OPS [9] = '{OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_EOR,
                                      OP_ADDI, OP_SUBI, OP_MOVZ, OP_MOVK};

  typedef uop_t [SLOTS-1:0] slot_vec_t;

  logic              clk_in;
  logic              reset;
  logic              flush;
  logic              fetch_valid;
  logic [INSN_W-1:0] fetch_insn [LANES];
  logic [PC_W-1:0]   fetch_pc;
  logic              exe_ready;
  logic              decode_ready;
  uop_t              issue_slots [SLOTS];

  bit        model_buffered;
  logic      model_ready;
  slot_vec_t model_slots;
  slot_vec_t model_buf;

  clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clk (
    .clk_in (clk_in),
    .reset  (reset)
  );

  decode_top #(.LANES(LANES)) u_dut (
    .clk_in       (clk_in),
    .reset        (reset),
    .flush        (flush),
    .fetch_valid  (fetch_valid),
    .fetch_insn   (fetch_insn),
    .fetch_pc     (fetch_pc),
    .exe_ready    (exe_ready),
    .decode_ready (decode_ready),
    .issue_slots  (issue_slots)
  );

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_uop(input string name, input uop_t got, input uop_t exp);
    if (got !== exp) begin
      $display("mismatch: time %0t ns, %s, got %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch: time %0t ns, %s, got %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // expected uops of one instruction
  function automatic void predict_lane(input logic [31:0] insn, input logic [63:0] pc,
                                       output uop_t first, output uop_t second,
                                       output int n, output bit stop);
    logic [5:0] opc;
    logic [8:0] off;
    uop_t       u;
    uop_t       acc;

    opc        = insn[31:26];
    off        = insn[20:12];
    u          = '0;
    u.pc       = pc;
    u.tx_begin = 1'b1;
    u.tx_end   = 1'b1;
    first      = '0;
    second     = '0;
    n          = 0;
    stop       = 1'b0;
    case (opc)
      OP_ADD, OP_ADDI: u.uopcode = UOP_ADD;
      OP_SUB, OP_SUBI: u.uopcode = UOP_SUB;
      OP_AND:          u.uopcode = UOP_AND;
      OP_ORR:          u.uopcode = UOP_ORR;
      OP_EOR:          u.uopcode = UOP_EOR;
      OP_MOVZ:         u.uopcode = UOP_MOVZ;
      OP_MOVK:         u.uopcode = UOP_MOVK;
      OP_HLT:          u.uopcode = UOP_HLT;
      default:         u.uopcode = UOP_NOP;
    endcase
    case (opc)
      OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_EOR: begin
        u.dst      = insn[4:0];
        u.src1     = insn[9:5];
        u.src2     = insn[20:16];
        u.w_enable = 1'b1;
        first      = u;
        n          = 1;
      end
      OP_ADDI, OP_SUBI, OP_MOVZ, OP_MOVK: begin
        u.dst      = insn[4:0];
        u.src1     = (opc == OP_ADDI || opc == OP_SUBI) ? insn[9:5] : 5'd0;
        u.imm      = (opc == OP_MOVZ || opc == OP_MOVK) ? insn[20:5] : {4'b0, insn[21:10]};
        u.use_imm  = 1'b1;
        u.w_enable = 1'b1;
        first      = u;
        n          = 1;
      end
      OP_LDUR, OP_STUR: begin
        acc           = u;
        acc.uopcode   = (opc == OP_LDUR) ? UOP_LOAD : UOP_STORE;
        acc.src1      = insn[9:5];
        acc.dst       = (opc == OP_LDUR) ? insn[4:0] : 5'd0;
        acc.src2      = (opc == OP_STUR) ? insn[4:0] : 5'd0;
        acc.mem_read  = (opc == OP_LDUR);
        acc.mem_write = (opc == OP_STUR);
        acc.w_enable  = (opc == OP_LDUR);
        if (off != 9'd0) begin
          acc.tx_begin = 1'b0;
          u.uopcode    = UOP_ADD;
          u.dst        = insn[9:5];
          u.src1       = insn[9:5];
          u.imm        = {7'b0, off};
          u.use_imm    = 1'b1;
          u.w_enable   = 1'b1;
          u.tx_end     = 1'b0;
          first        = u;
          second       = acc;
          n            = 2;
        end else begin
          first = acc;
          n     = 1;
        end
      end
      OP_HLT: begin
        first = u;
        n     = 1;
      end
      OP_B: stop = 1'b1;
      default: n = 0;
    endcase
  endfunction

  function automatic slot_vec_t predict_decoded();
    slot_vec_t v;
    uop_t      f;
    uop_t      s;
    int        n;
    int        pos;
    bit        st;
    bit        done;

    v    = '0;
    pos  = 0;
    done = 1'b0;
    for (int i = 0; i < LANES; i++) begin
      if (!done) begin
        predict_lane(fetch_insn[i], fetch_pc + 64'(4 * i), f, s, n, st);
        if (n >= 1) begin
          v[pos] = f;
        end
        if (n == 2) begin
          v[pos+1] = s;
        end
        pos  = pos + n;
        done = st;  // branch drops the lanes behind it
      end
    end
    return v;
  endfunction

  // one clock of the EMPTY/BUFFERED stage on the inputs sampled at the edge
  task automatic step_model();
    slot_vec_t dec;
    bit        accept;

    dec    = predict_decoded();
    accept = fetch_valid && model_ready;
    if (reset || flush) begin
      model_buffered = 1'b0;
      model_ready    = 1'b0;
      model_slots    = '0;
    end else begin
      if (!model_buffered) begin
        if (exe_ready) begin
          model_slots = accept ? dec : '0;
        end else if (accept) begin
          model_buf      = dec;
          model_buffered = 1'b1;
        end
      end else if (exe_ready) begin
        model_slots    = model_buf;
        model_buffered = 1'b0;
      end
      model_ready = !model_buffered;
    end
  endtask

  function automatic logic [31:0] random_insn();
    logic [31:0] insn;
    logic [5:0]  opc;
    int unsigned pick;

    pick = $urandom % 32;
    if (pick < 2) begin
      opc = 6'h20 | 6'($urandom % 16);  // unused codes
    end else if (pick == 2) begin
      opc = OP_B;
    end else if (pick == 3) begin
      opc = OP_HLT;
    end else if (pick == 4) begin
      opc = OP_NOP;
    end else if (pick < 12) begin
      opc = pick[0] ? OP_LDUR : OP_STUR;
    end else begin
      opc = ALU_OPS[$urandom % 9];
    end
    insn        = $urandom;
    insn[31:26] = opc;
    if ((opc == OP_LDUR || opc == OP_STUR) && ($urandom % 3) == 0) begin
      insn[20:12] = '0;
    end
    return insn;
  endfunction

  task automatic drive_stimulus();
    logic [63:0] pc;

    pc          = {$urandom, $urandom};
    pc[1:0]     = 2'b00;
    fetch_pc    = pc;
    fetch_valid = ($urandom % 4) != 0;
    exe_ready   = ($urandom % 3) != 0;
    flush       = ($urandom % 64) == 0;  // rare
    for (int i = 0; i < LANES; i++) begin
      fetch_insn[i] = random_insn();
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    abort_run();
  end

  initial begin
    void'($urandom(SEED));
    flush          = 1'b0;
    fetch_valid    = 1'b0;
    exe_ready      = 1'b0;
    fetch_pc       = '0;
    fetch_insn     = '{default: '0};
    model_buffered = 1'b0;
    model_ready    = 1'b0;
    model_slots    = '0;
    model_buf      = '0;
    for (int cyc = 0; cyc < RESET_CYCLES + N_CYCLES; cyc++) begin
      @(posedge clk_in);
      #1;
      step_model();
      check_ready("decode_ready", decode_ready, model_ready);
      for (int s = 0; s < SLOTS; s++) begin
        check_uop($sformatf("issue_slots[%0d]", s), issue_slots[s], model_slots[s]);
      end
      #1;
      drive_stimulus();
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: sim/decode_assert.sv
module decode_assert #(
  parameter int LANES = 2
) (
  input logic          clk_in,
  input logic          reset,
  input logic          flush,
  input logic          exe_ready,
  input logic          decode_ready,
  input uop_pkg::uop_t issue_slots [2*LANES]
);
  timeunit 1ns;
  timeprecision 100ps;
  import uop_pkg::*;

  localparam int UOP_W = $bits(uop_t);

  logic [2*LANES*UOP_W-1:0] slots_flat;

  always_comb begin
    for (int s = 0; s < 2*LANES; s++) begin
      slots_flat[s*UOP_W +: UOP_W] = issue_slots[s];
    end
  end

  a_ready_in_reset: assert property (@(posedge clk_in) reset |=> !decode_ready)
    else $error("decode_ready high after a reset cycle");

  a_ready_after_flush: assert property (
    @(posedge clk_in) disable iff (reset) flush |=> !decode_ready
  ) else $error("decode_ready high in the cycle after flush");

  // execute stalled, output must hold
  a_slots_hold: assert property (
    @(posedge clk_in) disable iff (reset) (!exe_ready && !flush) |=> $stable(slots_flat)
  ) else $error("issue_slots changed while exe_ready was low");

endmodule

bind decode_top decode_assert #(.LANES(LANES)) u_assert (
  .clk_in       (clk_in),
  .reset        (reset),
  .flush        (flush),
  .exe_ready    (exe_ready),
  .decode_ready (decode_ready),
  .issue_slots  (issue_slots)
);

// File: sim/clk_gen.sv
module clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_in,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_in = 1'b0;
    forever #(PERIOD_NS / 2) clk_in = ~clk_in;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_in);
    #2 reset = 1'b0;  // released off the edge like the other inputs
  end

endmodule

// File: hw/decode_top.sv
module decode_top #(
  parameter int LANES = 2
) (
  input  logic                       clk_in,
  input  logic                       reset,
  input  logic                       flush,
  input  logic                       fetch_valid,
  input  logic [isa_pkg::INSN_W-1:0] fetch_insn  [LANES],
  input  logic [isa_pkg::PC_W-1:0]   fetch_pc,
  input  logic                       exe_ready,
  output logic                       decode_ready,
  output uop_pkg::uop_t              issue_slots [2*LANES]
);
  import isa_pkg::*;
  import uop_pkg::*;

  localparam int SLOT_W = $clog2(2*LANES);

  logic [PC_W-1:0]   lane_pc    [LANES];
  lane_dec_t         lane_dec   [LANES];
  logic [1:0]        lane_n     [LANES];
  logic              lane_stop  [LANES];
  logic              keep       [LANES];
  logic [SLOT_W-1:0] start_slot [LANES];
  uop_t              decoded    [2*LANES];
  logic              load_buf;
  logic              load_out;
  out_sel_e          out_sel;

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    assign lane_pc[i]   = fetch_pc + PC_W'(4 * i);  // 4 bytes per instruction
    assign lane_n[i]    = lane_dec[i].n_uops;
    assign lane_stop[i] = lane_dec[i].stop;

    insn_cracker u_cracker (
      .insn    (fetch_insn[i]),
      .lane_pc (lane_pc[i]),
      .dec     (lane_dec[i])
    );
  end

  slot_allocator #(.LANES(LANES)) u_alloc (
    .n_uops     (lane_n),
    .stop       (lane_stop),
    .keep       (keep),
    .start_slot (start_slot)
  );

  bundle_assembler #(.LANES(LANES)) u_assemble (
    .lane_dec   (lane_dec),
    .keep       (keep),
    .start_slot (start_slot),
    .slots      (decoded)
  );

  issue_fsm u_fsm (
    .clk_in       (clk_in),
    .reset        (reset),
    .flush        (flush),
    .fetch_valid  (fetch_valid),
    .exe_ready    (exe_ready),
    .decode_ready (decode_ready),
    .load_buf     (load_buf),
    .load_out     (load_out),
    .out_sel      (out_sel)
  );

  bundle_regs #(.LANES(LANES)) u_regs (
    .clk_in      (clk_in),
    .reset       (reset),
    .decoded     (decoded),
    .load_buf    (load_buf),
    .load_out    (load_out),
    .out_sel     (out_sel),
    .issue_slots (issue_slots)
  );

endmodule

// File: hw/bundle_regs.sv
module bundle_regs #(
  parameter int LANES = 2
) (
  input  logic              clk_in,
  input  logic              reset,
  input  uop_pkg::uop_t     decoded     [2*LANES],
  input  logic              load_buf,
  input  logic              load_out,
  input  uop_pkg::out_sel_e out_sel,
  output uop_pkg::uop_t     issue_slots [2*LANES]
);
  import uop_pkg::*;

  localparam int SLOTS = 2*LANES;

  uop_t skid_q [SLOTS];  // holds one bundle while execute stalls

  always_ff @(posedge clk_in) begin
    if (load_buf) begin
      skid_q <= decoded;
    end
  end

  always_ff @(posedge clk_in) begin
    for (int s = 0; s < SLOTS; s++) begin
      if (reset) begin
        issue_slots[s] <= NOP_UOP;
      end else if (load_out) begin
        case (out_sel)
          NEW:     issue_slots[s] <= decoded[s];
          BUF:     issue_slots[s] <= skid_q[s];
          default: issue_slots[s] <= NOP_UOP;
        endcase
      end
    end
  end

endmodule

// File: hw/issue_fsm.sv
module issue_fsm (
  input  logic              clk_in,
  input  logic              reset,
  input  logic              flush,
  input  logic              fetch_valid,
  input  logic              exe_ready,
  output logic              decode_ready,
  output logic              load_buf,
  output logic              load_out,
  output uop_pkg::out_sel_e out_sel
);
  import uop_pkg::*;

  typedef enum logic {EMPTY, BUFFERED} state_e;

  state_e state;
  state_e state_next;
  logic   accept;

  assign accept = fetch_valid && decode_ready;

  always_comb begin
    state_next = state;
    load_buf   = 1'b0;
    load_out   = 1'b0;
    out_sel    = NOP;
    if (flush) begin
      state_next = EMPTY;
      load_out   = 1'b1;  // drop everything, issue nops
    end else begin
      case (state)
        EMPTY: begin
          if (exe_ready) begin
            load_out = 1'b1;
            out_sel  = accept ? NEW : NOP;
          end else if (accept) begin
            load_buf   = 1'b1;  // execute stalled, park the bundle
            state_next = BUFFERED;
          end
        end
        BUFFERED: begin
          if (exe_ready) begin
            load_out   = 1'b1;
            out_sel    = BUF;
            state_next = EMPTY;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (reset) begin
      state        <= EMPTY;
      decode_ready <= 1'b0;
    end else begin
      state        <= state_next;
      decode_ready <= !flush && (state_next == EMPTY);
    end
  end

endmodule

// File: hw/bundle_assembler.sv
module bundle_assembler #(
  parameter int LANES = 2
) (
  input  uop_pkg::lane_dec_t         lane_dec   [LANES],
  input  logic                       keep       [LANES],
  input  logic [$clog2(2*LANES)-1:0] start_slot [LANES],
  output uop_pkg::uop_t              slots      [2*LANES]
);
  import uop_pkg::*;

  localparam int SLOTS  = 2*LANES;
  localparam int SLOT_W = $clog2(SLOTS);

  always_comb begin
    for (int s = 0; s < SLOTS; s++) begin
      slots[s] = NOP_UOP;
    end
    for (int i = 0; i < LANES; i++) begin
      if (keep[i] && lane_dec[i].n_uops != 2'd0) begin
        slots[start_slot[i]] = lane_dec[i].first;
        if (lane_dec[i].n_uops == 2'd2) begin
          slots[SLOT_W'(start_slot[i] + 1'b1)] = lane_dec[i].second;
        end
      end
    end
  end

endmodule

// File: hw/slot_allocator.sv
module slot_allocator #(
  parameter int LANES = 2
) (
  input  logic [1:0]                   n_uops     [LANES],
  input  logic                         stop       [LANES],
  output logic                         keep       [LANES],
  output logic [$clog2(2*LANES)-1:0]   start_slot [LANES]
);

  localparam int SLOT_W = $clog2(2*LANES);

  always_comb begin
    int   sum;
    logic blocked;

    sum     = 0;
    blocked = 1'b0;
    for (int i = 0; i < LANES; i++) begin
      keep[i]       = !blocked;  // the stopping lane itself is kept
      start_slot[i] = SLOT_W'(sum);
      sum           = sum + int'(n_uops[i]);
      if (stop[i]) begin
        blocked = 1'b1;
      end
    end
  end

endmodule

// File: hw/insn_cracker.sv
module insn_cracker (
  input  logic [isa_pkg::INSN_W-1:0] insn,
  input  logic [isa_pkg::PC_W-1:0]   lane_pc,
  output uop_pkg::lane_dec_t         dec
);
  import isa_pkg::*;
  import uop_pkg::*;

  opcode_e    opc;
  logic [4:0] rd;
  logic [4:0] rn;
  logic [4:0] rm;
  logic [8:0] off9;
  logic       is_load;
  uopcode_e   alu_uop;
  uop_t       base;
  uop_t       split_add;
  uop_t       access;

  assign opc     = opcode_e'(insn[OPC_HI:OPC_LO]);
  assign rd      = insn[RD_HI:RD_LO];
  assign rn      = insn[RN_HI:RN_LO];
  assign rm      = insn[RM_HI:RM_LO];
  assign off9    = insn[OFF9_HI:OFF9_LO];
  assign is_load = (opc == OP_LDUR);

  always_comb begin
    case (opc)
      OP_ADD, OP_ADDI: alu_uop = UOP_ADD;
      OP_SUB, OP_SUBI: alu_uop = UOP_SUB;
      OP_AND:          alu_uop = UOP_AND;
      OP_ORR:          alu_uop = UOP_ORR;
      OP_EOR:          alu_uop = UOP_EOR;
      OP_MOVZ:         alu_uop = UOP_MOVZ;
      OP_MOVK:         alu_uop = UOP_MOVK;
      default:         alu_uop = UOP_NOP;
    endcase
  end

  always_comb begin
    base          = NOP_UOP;
    base.pc       = lane_pc;
    base.tx_begin = 1'b1;
    base.tx_end   = 1'b1;

    // address add for a memory op with an offset, rn is updated in place
    split_add          = base;
    split_add.uopcode  = UOP_ADD;
    split_add.dst      = rn;
    split_add.src1     = rn;
    split_add.imm      = {7'b0, off9};
    split_add.use_imm  = 1'b1;
    split_add.w_enable = 1'b1;
    split_add.tx_end   = 1'b0;

    access           = base;
    access.uopcode   = is_load ? UOP_LOAD : UOP_STORE;
    access.src1      = rn;
    access.dst       = is_load ? rd : 5'd0;
    access.src2      = is_load ? 5'd0 : rd;  // store data register
    access.mem_read  = is_load;
    access.mem_write = !is_load;
    access.w_enable  = is_load;
    access.tx_begin  = (off9 == 9'd0);
  end

  always_comb begin
    dec        = '0;
    dec.first  = base;
    dec.second = NOP_UOP;
    case (opc)
      OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_EOR: begin
        dec.first.uopcode  = alu_uop;
        dec.first.dst      = rd;
        dec.first.src1     = rn;
        dec.first.src2     = rm;
        dec.first.w_enable = 1'b1;
        dec.n_uops         = 2'd1;
      end
      OP_ADDI, OP_SUBI: begin
        dec.first.uopcode  = alu_uop;
        dec.first.dst      = rd;
        dec.first.src1     = rn;
        dec.first.imm      = {4'b0, insn[IMM12_HI:IMM12_LO]};
        dec.first.use_imm  = 1'b1;
        dec.first.w_enable = 1'b1;
        dec.n_uops         = 2'd1;
      end
      OP_MOVZ, OP_MOVK: begin
        dec.first.uopcode  = alu_uop;
        dec.first.dst      = rd;
        dec.first.imm      = insn[IMM16_HI:IMM16_LO];
        dec.first.use_imm  = 1'b1;
        dec.first.w_enable = 1'b1;
        dec.n_uops         = 2'd1;
      end
      OP_LDUR, OP_STUR: begin
        if (off9 != 9'd0) begin
          dec.first  = split_add;
          dec.second = access;
          dec.n_uops = 2'd2;
        end else begin
          dec.first  = access;
          dec.n_uops = 2'd1;
        end
      end
      OP_HLT: begin
        dec.first.uopcode = UOP_HLT;
        dec.n_uops        = 2'd1;
      end
      OP_B: dec.stop = 1'b1;  // resolved at fetch, only ends the bundle
      default: dec.first = NOP_UOP;  // nop and unknown opcodes
    endcase
  end

endmodule

// File: hw/uop_pkg.sv
package uop_pkg;

  typedef enum logic [3:0] {
    UOP_NOP   = 4'd0,
    UOP_ADD   = 4'd1,
    UOP_SUB   = 4'd2,
    UOP_AND   = 4'd3,
    UOP_ORR   = 4'd4,
    UOP_EOR   = 4'd5,
    UOP_MOVZ  = 4'd6,
    UOP_MOVK  = 4'd7,
    UOP_LOAD  = 4'd8,
    UOP_STORE = 4'd9,
    UOP_HLT   = 4'd10
  } uopcode_e;

  typedef struct packed {
    uopcode_e                  uopcode;
    logic [4:0]                dst;
    logic [4:0]                src1;
    logic [4:0]                src2;
    logic [15:0]               imm;
    logic                      use_imm;  // operand b is imm, not src2
    logic                      mem_read;
    logic                      mem_write;
    logic                      w_enable;
    logic                      tx_begin;  // first uop of the instruction
    logic                      tx_end;    // last uop of the instruction
    logic [isa_pkg::PC_W-1:0]  pc;
  } uop_t;

  // empty slot, all fields zero
  parameter uop_t NOP_UOP = '0;

  typedef struct packed {
    uop_t       first;
    uop_t       second;
    logic [1:0] n_uops;
    logic       stop;  // lanes after this one are dropped
  } lane_dec_t;

  // source of the next issue_slots value
  typedef enum logic [1:0] {NOP, NEW, BUF} out_sel_e;

endpackage

// File: hw/isa_pkg.sv
package isa_pkg;

  parameter int INSN_W = 32;
  parameter int PC_W   = 64;

  // opcode lives in the top six bits of every instruction
  typedef enum logic [5:0] {
    OP_NOP  = 6'h00,
    OP_ADD  = 6'h01,
    OP_SUB  = 6'h02,
    OP_AND  = 6'h03,
    OP_ORR  = 6'h04,
    OP_EOR  = 6'h05,
    OP_ADDI = 6'h08,
    OP_SUBI = 6'h09,
    OP_MOVZ = 6'h0c,
    OP_MOVK = 6'h0d,
    OP_LDUR = 6'h10,
    OP_STUR = 6'h11,
    OP_B    = 6'h18,
    OP_HLT  = 6'h3e
  } opcode_e;

  parameter int OPC_HI   = 31;
  parameter int OPC_LO   = 26;
  parameter int RD_HI    = 4;
  parameter int RD_LO    = 0;
  parameter int RN_HI    = 9;
  parameter int RN_LO    = 5;
  parameter int RM_HI    = 20;
  parameter int RM_LO    = 16;
  parameter int IMM12_HI = 21;  // addi / subi
  parameter int IMM12_LO = 10;
  parameter int IMM16_HI = 20;  // movz / movk
  parameter int IMM16_LO = 5;
  parameter int OFF9_HI  = 20;  // ldur / stur
  parameter int OFF9_LO  = 12;

endpackage
